//--- hw/alu.sv
`timescale 1ns/100ps

module alu
    import la32_pkg::*;
(
    input  alu_op_t alu_op,
    input  word_t   alu_src1,
    input  word_t   alu_src2,
    output word_t   alu_result
);

    word_t    addsub_b;
    word_t    addsub_res;
    word_t    slt_res;
    word_t    sltu_res;
    word_t    sll_res;
    word_t    srl_res;
    word_t    sra_res;
    logic [4:0] shamt;

    // Shared adder, subtract by inverting src2.
    assign addsub_b   = alu_op[ALU_SUB] ? ~alu_src2 : alu_src2;
    assign addsub_res = alu_src1 + addsub_b + {31'b0, alu_op[ALU_SUB]};

    assign slt_res  = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
    assign sltu_res = {31'b0, alu_src1 < alu_src2};

    assign shamt   = alu_src2[4:0];
    assign sll_res = alu_src1 << shamt;
    assign srl_res = alu_src1 >> shamt;
    assign sra_res = $signed(alu_src1) >>> shamt;

    always_comb begin
        alu_result = ({32{alu_op[ALU_ADD] | alu_op[ALU_SUB]}} & addsub_res)
                   | ({32{alu_op[ALU_SLT]}}  & slt_res)
                   | ({32{alu_op[ALU_SLTU]}} & sltu_res)
                   | ({32{alu_op[ALU_AND]}}  & (alu_src1 & alu_src2))
                   | ({32{alu_op[ALU_NOR]}}  & ~(alu_src1 | alu_src2))
                   | ({32{alu_op[ALU_OR]}}   & (alu_src1 | alu_src2))
                   | ({32{alu_op[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
                   | ({32{alu_op[ALU_SLL]}}  & sll_res)
                   | ({32{alu_op[ALU_SRL]}}  & srl_res)
                   | ({32{alu_op[ALU_SRA]}}  & sra_res)
                   | ({32{alu_op[ALU_LUI]}}  & alu_src2);  // Immediate already shifted.
    end

    // Exactly one operation selected.
    always_comb begin
        a_op_onehot : assert ($onehot(alu_op))
            else $error("alu: alu_op %h is not one-hot", alu_op);
    end

endmodule

//--- hw/cpu_control.sv
`timescale 1ns/100ps

module cpu_control
    import la32_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  ctrl_t      ctrl,
    output cpu_state_t state,
    output logic       ir_we,
    output logic       res_we,
    output logic       pc_we,
    output logic       rf_we,
    output logic       data_we
);

    cpu_state_t next_state;
    logic       pc_pending;
    logic       stored;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IF;
        end else begin
            state <= next_state;
        end
    end

    // Decode is valid from EXE on, so the path splits there.
    always_comb begin
        case (state)
            ST_IF:   next_state = ST_ID;
            ST_ID:   next_state = ST_EXE;
            ST_EXE: begin
                if (ctrl.is_load || ctrl.is_store) begin
                    next_state = ST_MEM;
                end else if (ctrl.gr_we) begin
                    next_state = ST_WB;
                end else begin
                    next_state = ST_IF;   // b, beq, bne.
                end
            end
            ST_MEM:  next_state = ctrl.is_load ? ST_WB : ST_IF;
            ST_WB:   next_state = ST_IF;
            default: next_state = ST_IF;
        endcase
    end

    assign ir_we   = (state == ST_ID);
    assign res_we  = (state == ST_EXE);
    assign rf_we   = (state == ST_WB) && ctrl.gr_we;
    assign data_we = (state == ST_MEM) && ctrl.is_store;
    assign pc_we   = (state != ST_IF) && (next_state == ST_IF);  // Last cycle.

    // ##########################################################
    // Checks.
    // ##########################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_pending <= 1'b0;
        end else if (ir_we) begin
            pc_pending <= 1'b1;
        end else if (pc_we) begin
            pc_pending <= 1'b0;
        end
    end

    // Data write seen for the instruction in flight.
    always_ff @(posedge clk) begin
        if (reset) begin
            stored <= 1'b0;
        end else if (ir_we) begin
            stored <= 1'b0;
        end else if (data_we) begin
            stored <= 1'b1;
        end
    end

    // One instruction writes memory or a register, never both.
    a_we_exclusive : assert property (@(posedge clk) disable iff (reset)
        !(rf_we && (data_we || stored)))
        else $error("cpu_control: rf_we and data_we in one instruction");

    // Exactly one PC update between two instruction captures.
    a_pc_once : assert property (@(posedge clk) disable iff (reset)
        pc_we |-> pc_pending)
        else $error("cpu_control: second pc_we for one instruction");

    a_pc_done : assert property (@(posedge clk) disable iff (reset)
        ir_we |-> !pc_pending)
        else $error("cpu_control: instruction retired without pc_we");

endmodule

//--- hw/la32_decoder.sv
`timescale 1ns/100ps

module la32_decoder
    import la32_pkg::*;
(
    input  word_t inst,
    output ctrl_t ctrl,
    output word_t imm,
    output word_t br_offs,
    output word_t jirl_offs,
    output logic  illegal
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    reg_idx_t    rd;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        grp_3r;
    logic        grp_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w;
    logic        inst_ld_w, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    alu_op_t     op_sel;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};

    // ##########################################################
    // Opcode match.
    // ##########################################################
    assign grp_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign grp_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = grp_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = grp_3r && (op_19_15 == 5'h02);
    assign inst_slt     = grp_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = grp_3r && (op_19_15 == 5'h05);
    assign inst_nor     = grp_3r && (op_19_15 == 5'h08);
    assign inst_and     = grp_3r && (op_19_15 == 5'h09);
    assign inst_or      = grp_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = grp_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = grp_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = grp_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = grp_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    assign illegal = !(inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                     | inst_and | inst_or | inst_xor | inst_slli_w | inst_srli_w
                     | inst_srai_w | inst_addi_w | inst_lu12i_w | inst_ld_w
                     | inst_st_w | inst_jirl | inst_b | inst_bl | inst_beq | inst_bne);

    // Everything that selects no other operation adds.
    assign op_sel = {inst_lu12i_w, inst_srai_w, inst_srli_w, inst_slli_w,
                     inst_xor, inst_or, inst_nor, inst_and,
                     inst_sltu, inst_slt, inst_sub_w, 1'b0};

    always_comb begin
        ctrl.alu_op      = op_sel | {11'b0, ~|op_sel};
        ctrl.src1_is_pc  = inst_jirl | inst_bl;
        ctrl.src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                         | inst_lu12i_w | inst_ld_w | inst_st_w | inst_jirl | inst_bl;
        ctrl.is_load     = inst_ld_w;
        ctrl.is_store    = inst_st_w;
        ctrl.is_beq      = inst_beq;
        ctrl.is_bne      = inst_bne;
        ctrl.is_jump     = inst_b | inst_bl | inst_jirl;
        ctrl.is_jirl     = inst_jirl;
        ctrl.gr_we       = !illegal && !inst_st_w && !inst_beq && !inst_bne && !inst_b;
        ctrl.dest        = inst_bl ? 5'd1 : rd;
        ctrl.rs2_is_rd   = inst_beq | inst_bne | inst_st_w;
    end

    // Link value is PC+4.
    assign imm = (inst_jirl || inst_bl) ? 32'd4 :
                 inst_lu12i_w           ? {i20, 12'b0} :
                                          {{20{i12[11]}}, i12};

    assign br_offs   = (inst_b || inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                             {{14{i16[15]}}, i16, 2'b0};
    assign jirl_offs = {{14{i16[15]}}, i16, 2'b0};

endmodule

//--- hw/la32_pkg.sv
package la32_pkg;

    // ##########################################################
    // Widths.
    // ##########################################################
    typedef logic [31:0] word_t;     // Data, address or instruction word.
    typedef logic [4:0]  reg_idx_t;  // GPR number.
    typedef logic [11:0] alu_op_t;   // One-hot ALU select.

    // Bit positions inside alu_op_t.
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // ##########################################################
    // Sequencer states.
    // ##########################################################
    typedef enum logic [2:0] {
        ST_IF,
        ST_ID,
        ST_EXE,
        ST_MEM,
        ST_WB
    } cpu_state_t;

    // Decoded instruction, held stable while the IR is.
    typedef struct packed {
        alu_op_t  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     is_load;
        logic     is_store;
        logic     is_beq;
        logic     is_bne;
        logic     is_jump;     // b, bl, jirl.
        logic     is_jirl;
        logic     gr_we;
        reg_idx_t dest;
        logic     rs2_is_rd;   // Second read port takes rd.
    } ctrl_t;

endpackage

//--- hw/mycpu_top.sv
`timescale 1ns/100ps

module mycpu_top
    import la32_pkg::*;
#(
    parameter word_t RESET_PC = 32'h1c000000
) (
    input  logic       clk,
    input  logic       reset,
    // Instruction SRAM.
    output logic       inst_sram_we,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata,
    // Data SRAM.
    output logic       data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,
    // Writeback trace.
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    word_t      pc;
    word_t      ir;
    word_t      res_q;
    ctrl_t      ctrl;
    word_t      imm, br_offs, jirl_offs;
    logic       illegal;
    reg_idx_t   rf_raddr2;
    word_t      rf_rdata1, rf_rdata2;
    word_t      alu_src1, alu_src2, alu_result;
    cpu_state_t state;
    logic       ir_we, res_we, pc_we, rf_we, data_we;
    logic       br_taken;
    word_t      br_target, next_pc, final_result;

    // ##########################################################
    // Architectural and stage registers.
    // ##########################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_we) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_we) ir <= inst_sram_rdata;
        if (res_we) res_q <= alu_result;
    end

    la32_decoder u_decoder (
        .inst      (ir),
        .ctrl      (ctrl),
        .imm       (imm),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs),
        .illegal   (illegal)
    );

    assign rf_raddr2 = ctrl.rs2_is_rd ? ir[4:0] : ir[14:10];

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ir[9:5]),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (ctrl.dest),
        .wdata  (final_result)
    );

    assign alu_src1 = ctrl.src1_is_pc ? pc : rf_rdata1;
    assign alu_src2 = ctrl.src2_is_imm ? imm : rf_rdata2;

    alu u_alu (
        .alu_op     (ctrl.alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    cpu_control u_control (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .state   (state),
        .ir_we   (ir_we),
        .res_we  (res_we),
        .pc_we   (pc_we),
        .rf_we   (rf_we),
        .data_we (data_we)
    );

    // Next PC, sampled only in the last cycle.
    assign br_taken  = ctrl.is_jump
                     || (ctrl.is_beq && (rf_rdata1 == rf_rdata2))
                     || (ctrl.is_bne && (rf_rdata1 != rf_rdata2));
    assign br_target = ctrl.is_jirl ? rf_rdata1 + jirl_offs : pc + br_offs;
    assign next_pc   = br_taken ? br_target : pc + 32'd4;

    assign final_result = ctrl.is_load ? data_sram_rdata : res_q;

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = '0;

    assign data_sram_we    = data_we;
    assign data_sram_addr  = res_q;
    assign data_sram_wdata = rf_rdata2;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = ctrl.dest;
    assign debug_wb_rf_wdata = final_result;

    // Program must stay inside the supported subset.
    a_legal : assert property (@(posedge clk) disable iff (reset)
        (state == ST_EXE) |-> !illegal)
        else $error("mycpu_top: illegal instruction %h at pc %h", ir, pc);

endmodule

//--- hw/regfile.sv
`timescale 1ns/100ps

module regfile
    import la32_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t raddr1,
    output word_t    rdata1,
    input  reg_idx_t raddr2,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
        rf[0] <= '0;  // r0 is hardwired.
    end

    assign rdata1 = rf[raddr1];
    assign rdata2 = rf[raddr2];

    // A write to r0 must never show up on a later read.
    a_r0_zero : assert property (@(posedge clk)
        (we && waddr == '0) |=> ((raddr1 != '0 || rdata1 == '0)
                              && (raddr2 != '0 || rdata2 == '0)))
        else $error("regfile: r0 read back nonzero");

endmodule

//--- la32_cpu.f
hw/la32_pkg.sv
hw/la32_decoder.sv
hw/regfile.sv
hw/alu.sv
hw/cpu_control.sv
hw/mycpu_top.sv
+incdir+test
test/tb_mycpu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LA32R CPU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mycpu -f la32_cpu.f -o sim_tb_mycpu

./obj_dir/sim_tb_mycpu > sim.log 2>&1 || true
cat sim.log

if ! grep -q "Test completed successfully" sim.log; then
    exit 1
fi
exit 0

//--- test/la32_ref_model.svh
`ifndef LA32_REF_MODEL_SVH
`define LA32_REF_MODEL_SVH

// ############################################################
// Random program generator.
// ############################################################
task automatic emit(input word_t w);
    imem[pos] = w;
    pos++;
endtask

function automatic reg_idx_t any_reg();
    return reg_idx_t'(next_rand() % 16);
endfunction

function automatic reg_idx_t nz_reg();
    return reg_idx_t'(1 + next_rand() % 15);
endfunction

// Register-register op or immediate shift into rd.
task automatic emit_alu(input reg_idx_t rd);
    logic [16:0] f;
    word_t       r;
    int          sel;
    reg_idx_t    rk;
    r   = next_rand();
    sel = int'(r % 11);
    case (sel)
        0:       f = 17'h00020;
        1:       f = 17'h00022;
        2:       f = 17'h00024;
        3:       f = 17'h00025;
        4:       f = 17'h00028;
        5:       f = 17'h00029;
        6:       f = 17'h0002a;
        7:       f = 17'h0002b;
        8:       f = 17'h00081;
        9:       f = 17'h00089;
        default: f = 17'h00091;
    endcase
    rk = (sel >= 8) ? r[20:16] : any_reg();  // Shift amount for shifts.
    emit({f, rk, any_reg(), rd});
endtask

task automatic gen_program(input int mode, output word_t end_pc);
    word_t    r;
    word_t    tgt;
    int       skip;
    reg_idx_t rx;
    pos = 0;
    for (int i = 1; i < 16; i++) begin  // Seed r1..r15.
        r = next_rand();
        emit({7'b0001010, r[31:12], reg_idx_t'(i)});
        emit({10'h00a, r[11:0], reg_idx_t'(i), reg_idx_t'(i)});
    end
    for (int n = 0; n < 40; n++) begin
        r    = next_rand();
        skip = int'(r[9:8]);
        case (mode)
            0: emit({10'h00a, r[21:10], any_reg(), nz_reg()});
            1: emit_alu(nz_reg());
            2: begin
                if (r % 3 == 0) begin
                    emit({10'h00a, r[21:10], any_reg(), r[4] ? 5'd0 : nz_reg()});
                end else if (r % 3 == 1) begin
                    emit({7'b0001010, r[31:12], r[5] ? 5'd0 : nz_reg()});
                end else begin
                    emit_alu(nz_reg());
                end
            end
            3: begin
                if (r % 3 == 0) begin
                    emit({10'h0a6, 2'b0, r[17:10], 2'b0, 5'd0, any_reg()});
                end else if (r % 3 == 1) begin
                    emit({10'h0a2, 2'b0, r[17:10], 2'b0, 5'd0, nz_reg()});
                end else begin
                    emit_alu(nz_reg());
                end
            end
            default: begin
                case (r % 6)
                    0: emit({6'h16, 16'(skip + 1), any_reg(), any_reg()});
                    1: emit({6'h17, 16'(skip + 1), any_reg(), any_reg()});
                    2: emit({6'h14, 16'(skip + 1), 10'd0});
                    3: emit({6'h15, 16'(skip + 1), 10'd0});
                    4: begin
                        rx  = nz_reg();
                        tgt = RESET_PC + 4 * word_t'(pos + 3 + skip);
                        emit({7'b0001010, tgt[31:12], rx});
                        emit({10'h00a, tgt[11:0], rx, rx});
                        emit({6'h13, 16'd0, rx, any_reg()});
                    end
                    default: begin
                        emit_alu(nz_reg());
                        skip = 0;
                    end
                endcase
                for (int s = 0; s < skip; s++) begin  // Jumped over.
                    emit_alu(nz_reg());
                end
            end
        endcase
    end
    end_pc = RESET_PC + 4 * word_t'(pos);
    emit({6'h14, 26'd0});  // b to itself.
endtask

// ############################################################
// Instruction-level model.
// ############################################################
task automatic run_model(input word_t end_pc, output int n_exec);
    word_t    pc, w, a, b, res, nxt, si12, offs16, addr;
    reg_idx_t rd;
    logic     we;
    pc     = RESET_PC;
    n_exec = 0;
    while (pc != end_pc && n_exec < 4000) begin
        w      = imem[pc[11:2]];
        rd     = w[4:0];
        a      = mrf[w[9:5]];
        b      = mrf[w[14:10]];
        si12   = {{20{w[21]}}, w[21:10]};
        offs16 = {{14{w[25]}}, w[25:10], 2'b0};
        addr   = a + si12;
        we     = 1'b1;
        res    = '0;
        nxt    = pc + 4;
        casez (w[31:15])
            17'h00020: res = a + b;
            17'h00022: res = a - b;
            17'h00024: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            17'h00025: res = (a < b) ? 32'd1 : 32'd0;
            17'h00028: res = ~(a | b);
            17'h00029: res = a & b;
            17'h0002a: res = a | b;
            17'h0002b: res = a ^ b;
            17'h00081: res = a << w[14:10];
            17'h00089: res = a >> w[14:10];
            17'h00091: res = $signed(a) >>> w[14:10];
            17'b0000001010???????: res = addr;
            17'b0001010??????????: res = {w[24:5], 12'b0};
            17'b0010100010???????: res = mmem[addr[9:2]];
            17'b0010100110???????: begin
                mmem[addr[9:2]] = mrf[rd];
                we = 1'b0;
            end
            17'b010011???????????: begin
                res = pc + 4;
                nxt = a + offs16;
            end
            17'b010100???????????: begin
                we  = 1'b0;
                nxt = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
            end
            17'b010101???????????: begin
                res = pc + 4;
                rd  = 5'd1;
                nxt = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
            end
            17'b010110???????????: begin
                we = 1'b0;
                if (a == mrf[rd]) nxt = pc + offs16;
            end
            17'b010111???????????: begin
                we = 1'b0;
                if (a != mrf[rd]) nxt = pc + offs16;
            end
            default: we = 1'b0;
        endcase
        if (we) begin
            exp_pc.push_back(pc);
            exp_num.push_back(rd);
            exp_data.push_back(res);
            if (rd != 5'd0) mrf[rd] = res;
        end
        pc = nxt;
        n_exec++;
    end
endtask

`endif

//--- test/tb_mycpu.sv
`timescale 1ns/100ps

module tb_mycpu
    import la32_pkg::*;
;

    localparam word_t RESET_PC = 32'h1c000000;

    logic       clk     = 1'b0;
    logic       reset   = 1'b1;
    logic       reset_q = 1'b0;
    word_t      inst_sram_rdata = '0;
    word_t      data_sram_rdata = '0;
    logic       inst_sram_we, data_sram_we;
    word_t      inst_sram_addr, inst_sram_wdata, data_sram_addr, data_sram_wdata;
    word_t      debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;

    word_t    imem [1024];
    word_t    dmem [256];
    word_t    mmem [256];    // Model memory.
    word_t    mrf  [32];     // Model registers.
    word_t    exp_pc[$], exp_data[$];
    reg_idx_t exp_num[$];
    word_t    rng = 32'h201f3d82;
    int       pos, errs, pass_cnt, fail_cnt;
    int       cycle = 0;
    int       deadline = 2000;
    bit       first_wb = 1'b0;

    function word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t fill_word(input int i);
        return (word_t'(i) * 32'h9e3779b1) ^ word_t'(i);
    endfunction

    `include "la32_ref_model.svh"

    always #20 clk = ~clk;

    mycpu_top #(.RESET_PC(RESET_PC)) dut (.*);

    // ############################################################
    // SRAM models, one-cycle read.
    // ############################################################
    always @(posedge clk) begin
        reset_q         <= reset;
        inst_sram_rdata <= imem[inst_sram_addr[11:2]];
        data_sram_rdata <= dmem[data_sram_addr[9:2]];
        if (reset) begin
            for (int i = 0; i < 256; i++) dmem[i] <= fill_word(i);
        end else if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    // Trace checker.
    always @(negedge clk) begin
        assert (inst_sram_we == 1'b0)
        else begin
            $display("error: inst_sram_we %h, expected 0", inst_sram_we);
            errs++;
        end
        assert (inst_sram_wdata == '0)
        else begin
            $display("error: inst_sram_wdata %h, expected 00000000", inst_sram_wdata);
            errs++;
        end
        if (reset) begin
            if (reset_q) begin
                assert (debug_wb_rf_we == 4'h0 && !data_sram_we)
                else begin
                    $display("A write was seen while reset was high");
                    errs++;
                end
            end
        end else if (debug_wb_rf_we != 4'h0) begin
            assert (debug_wb_rf_we == 4'hf)
            else begin
                $display("error: debug_wb_rf_we %h, expected f", debug_wb_rf_we);
                errs++;
            end
            assert (exp_pc.size() != 0)
            else begin
                $display("Register write beyond the expected trace");
                errs++;
            end
            if (exp_pc.size() != 0) begin
                if (first_wb) begin
                    assert (debug_wb_pc == RESET_PC)
                    else begin
                        $display("error: first debug_wb_pc %h, expected %h",
                                 debug_wb_pc, RESET_PC);
                        errs++;
                    end
                    first_wb = 1'b0;
                end
                assert (debug_wb_pc == exp_pc[0])
                else begin
                    $display("error: debug_wb_pc %h, expected %h", debug_wb_pc, exp_pc[0]);
                    errs++;
                end
                assert (debug_wb_rf_wnum == exp_num[0])
                else begin
                    $display("error: debug_wb_rf_wnum %h, expected %h",
                             debug_wb_rf_wnum, exp_num[0]);
                    errs++;
                end
                assert (debug_wb_rf_wdata == exp_data[0])
                else begin
                    $display("error: debug_wb_rf_wdata %h, expected %h at pc %h",
                             debug_wb_rf_wdata, exp_data[0], debug_wb_pc);
                    errs++;
                end
                void'(exp_pc.pop_front());
                void'(exp_num.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    // Watchdog.
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > deadline) begin
            $display("Timeout: the CPU did not reach the end of the program in time");
            $display("Test failed");
            $finish;
        end
    end

    task automatic run_test(input int mode, input string name);
        word_t end_pc;
        int    n;
        @(posedge clk);
        reset <= 1'b1;
        errs = 0;
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
        gen_program(mode, end_pc);
        for (int i = 0; i < 256; i++) mmem[i] = fill_word(i);
        for (int i = 0; i < 32; i++) mrf[i] = '0;
        run_model(end_pc, n);
        deadline = cycle + (n + 1) * 5 + 200 + 20;
        repeat (10) @(posedge clk);
        reset    <= 1'b0;
        first_wb = 1'b1;
        do @(negedge clk); while (!(debug_wb_pc == end_pc && exp_pc.size() == 0));
        repeat (2) @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            assert (dmem[i] == mmem[i])
            else begin
                $display("error: data_sram word %0d is %h, expected %h", i, dmem[i], mmem[i]);
                errs++;
            end
        end
        if (errs == 0) pass_cnt++;
        else fail_cnt++;
        $display("test %s: %0d instructions, %0d errors, %s",
                 name, n, errs, (errs == 0) ? "PASS" : "FAIL");
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) imem[i] = {6'h14, 26'd0};
        run_test(0, "reset");
        run_test(1, "alu");
        run_test(2, "immediate and r0");
        run_test(3, "load store");
        run_test(4, "control flow");
        $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
